/* source/go_geom_pkg.sv */
package go_geom_pkg;

    localparam int board_size = 9;

    // One-hot position along one axis.
    typedef logic [board_size-1:0] coord_t;

    // Bit i is column i.
    typedef logic [board_size-1:0] row_t;
    typedef row_t [board_size-1:0] plane_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    localparam coord_t cursor_home = 9'b0_0001_0000;
    localparam point_t scan_origin = '{x: coord_t'(1), y: coord_t'(1)};

    // Single bit at the point, nothing for a point off the board.
    function automatic plane_t point_mask(point_t p);
        plane_t m;
        for (int r = 0; r < board_size; r++) begin
            m[r] = p.y[r] ? p.x : '0;
        end
        return m;
    endfunction

    function automatic logic plane_bit(plane_t pl, point_t p);
        return |(pl & point_mask(p));
    endfunction

    function automatic logic on_board(point_t p);
        return (|p.x) && (|p.y);
    endfunction

    // Raster order, along the row first.
    function automatic point_t raster_next(point_t p);
        point_t n;
        n = p;
        if (p.x[board_size-1]) begin
            n.x = coord_t'(1);
            n.y = p.y << 1;
        end else begin
            n.x = p.x << 1;
        end
        return n;
    endfunction

    function automatic logic raster_last(point_t p);
        return p.x[board_size-1] && p.y[board_size-1];
    endfunction

endpackage

/* source/go_ctrl_pkg.sv */
package go_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_cap_dir,
        st_search,
        st_group_done,
        st_delete
    } engine_state_t;

    typedef enum logic [1:0] {
        dir_left,
        dir_right,
        dir_up,
        dir_down
    } dir_t;

    typedef struct packed {
        logic place;
        logic pass;
    } buttons_t;

    typedef struct packed {
        logic                set;
        logic                clear;
        logic                white;
        go_geom_pkg::point_t pt;
    } board_edit_t;

    // A step off the board leaves a zero coordinate.
    function automatic go_geom_pkg::point_t neighbour(go_geom_pkg::point_t p, dir_t d);
        go_geom_pkg::point_t n;
        n = p;
        case (d)
            dir_left:  n.x = p.x >> 1;
            dir_right: n.x = p.x << 1;
            dir_up:    n.y = p.y >> 1;
            default:   n.y = p.y << 1;
        endcase
        return n;
    endfunction

endpackage

/* source/cursor_ctrl.sv */
module cursor_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  up,
    input  logic                  down,
    input  logic                  left,
    input  logic                  right,
    input  logic                  place,
    input  logic                  pass,
    output go_geom_pkg::point_t   cursor,
    output go_ctrl_pkg::buttons_t buttons
);

    // Bit order is left, right, up, down, place, pass.
    logic [5:0]          levels;
    logic [5:0]          level_q;
    logic [5:0]          strobe;
    logic                move;
    go_ctrl_pkg::dir_t   move_dir;
    go_geom_pkg::point_t target;

    assign levels = {left, right, up, down, place, pass};
    assign move   = |strobe[5:2];

    always_comb begin
        move_dir = go_ctrl_pkg::dir_down;
        if (strobe[5]) begin
            move_dir = go_ctrl_pkg::dir_left;
        end else if (strobe[4]) begin
            move_dir = go_ctrl_pkg::dir_right;
        end else if (strobe[3]) begin
            move_dir = go_ctrl_pkg::dir_up;
        end
        target = go_ctrl_pkg::neighbour(cursor, move_dir);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= '0;
            strobe  <= '0;
            cursor  <= '{x: go_geom_pkg::cursor_home, y: go_geom_pkg::cursor_home};
        end else begin
            level_q <= levels;
            strobe  <= levels & ~level_q;
            // Stay put at the edge.
            if (move && go_geom_pkg::on_board(target)) begin
                cursor <= target;
            end
        end
    end

    assign buttons = '{place: strobe[1], pass: strobe[0]};

endmodule

/* source/board_store.sv */
module board_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  go_ctrl_pkg::board_edit_t edit,
    input  go_geom_pkg::point_t      cursor,
    input  logic                     show_cursor,
    input  logic                     turn_white,
    input  go_geom_pkg::point_t      probe,
    input  logic                     probe_white,
    output logic                     cursor_occ,
    output logic                     probe_hit,
    output go_geom_pkg::plane_t      black_plane,
    output go_geom_pkg::plane_t      white_plane,
    output logic                     black,
    output logic                     white,
    output go_geom_pkg::plane_t      rows
);

    logic                phase;
    logic                cursor_on;
    go_geom_pkg::plane_t edit_mask;
    go_geom_pkg::plane_t cursor_mask;

    assign edit_mask = go_geom_pkg::point_mask(edit.pt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase       <= 1'b0;
            black_plane <= '0;
            white_plane <= '0;
        end else begin
            phase <= ~phase;
            if (edit.white) begin
                if (edit.set) begin
                    white_plane <= white_plane | edit_mask;
                end else if (edit.clear) begin
                    white_plane <= white_plane & ~edit_mask;
                end
            end else begin
                if (edit.set) begin
                    black_plane <= black_plane | edit_mask;
                end else if (edit.clear) begin
                    black_plane <= black_plane & ~edit_mask;
                end
            end
        end
    end

    assign cursor_occ = go_geom_pkg::plane_bit(black_plane | white_plane, cursor);
    assign probe_hit  = go_geom_pkg::plane_bit(probe_white ? white_plane : black_plane, probe);

    // Phase 0 drives the black stones, phase 1 the white ones.
    assign black = ~phase;
    assign white = phase;

    // Cursor shows in the mover's phase, only over an empty point.
    assign cursor_on   = show_cursor && !cursor_occ && (phase == turn_white);
    assign cursor_mask = cursor_on ? go_geom_pkg::point_mask(cursor) : '0;
    assign rows        = (phase ? white_plane : black_plane) | cursor_mask;

endmodule

/* source/group_search.sv */
module group_search (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  go_geom_pkg::point_t seed,
    input  logic                search_white,
    input  go_geom_pkg::plane_t black_plane,
    input  go_geom_pkg::plane_t white_plane,
    input  go_geom_pkg::point_t probe,
    output logic                done,
    output logic                has_liberty,
    output logic                member
);

    logic                active;
    logic                expanding;
    logic                colour_white;
    go_geom_pkg::plane_t frontier;
    go_geom_pkg::plane_t visited;
    go_geom_pkg::point_t scan;
    go_geom_pkg::point_t cur;
    go_ctrl_pkg::dir_t   nbr_dir;

    go_geom_pkg::plane_t own_plane;
    go_geom_pkg::point_t nb;
    logic                nb_own;
    logic                nb_empty;
    logic                scan_hit;
    logic                last_dir;

    assign own_plane = colour_white ? white_plane : black_plane;
    assign nb        = go_ctrl_pkg::neighbour(cur, nbr_dir);
    assign last_dir  = nbr_dir == go_ctrl_pkg::dir_down;
    assign scan_hit  = go_geom_pkg::plane_bit(frontier, scan);

    // Same colour and not yet reached joins the frontier.
    assign nb_own   = go_geom_pkg::plane_bit(own_plane, nb)
                      && !go_geom_pkg::plane_bit(visited, nb);
    assign nb_empty = go_geom_pkg::on_board(nb)
                      && !go_geom_pkg::plane_bit(black_plane | white_plane, nb);

    assign member = go_geom_pkg::plane_bit(visited, probe);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active      <= 1'b0;
            expanding   <= 1'b0;
            done        <= 1'b0;
            has_liberty <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active      <= 1'b1;
                expanding   <= 1'b0;
                has_liberty <= 1'b0;
            end else if (active && expanding) begin
                if (nb_empty) begin
                    has_liberty <= 1'b1;
                end
                if (last_dir) begin
                    expanding <= 1'b0;
                end
            end else if (active) begin
                if (scan_hit) begin
                    expanding <= 1'b1;
                end else if (go_geom_pkg::raster_last(scan)) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // Pop one frontier point, then look at its four neighbours.
    always_ff @(posedge clk) begin
        if (start) begin
            colour_white <= search_white;
            frontier     <= go_geom_pkg::point_mask(seed);
            visited      <= '0;
            scan         <= go_geom_pkg::scan_origin;
        end else if (active && expanding) begin
            if (nb_own) begin
                frontier <= frontier | go_geom_pkg::point_mask(nb);
            end
            nbr_dir <= go_ctrl_pkg::dir_t'(nbr_dir + 2'd1);
            // New frontier bits may lie behind the scan.
            if (last_dir) begin
                scan <= go_geom_pkg::scan_origin;
            end
        end else if (active) begin
            if (scan_hit) begin
                frontier <= frontier & ~go_geom_pkg::point_mask(scan);
                visited  <= visited | go_geom_pkg::point_mask(scan);
                cur      <= scan;
                nbr_dir  <= go_ctrl_pkg::dir_left;
            end else begin
                scan <= go_geom_pkg::raster_next(scan);
            end
        end
    end

endmodule

/* source/move_ctrl.sv */
module move_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  go_ctrl_pkg::buttons_t     buttons,
    input  go_geom_pkg::point_t       cursor,
    input  logic                      cursor_occ,
    input  logic                      probe_hit,
    input  logic                      search_done,
    input  logic                      has_liberty,
    input  logic                      member,
    output go_ctrl_pkg::board_edit_t  edit,
    output go_geom_pkg::point_t       probe,
    output logic                      probe_white,
    output logic                      search_start,
    output go_geom_pkg::point_t       seed,
    output logic                      search_white,
    output logic                      turn_white,
    output logic                      show_cursor,
    output logic                      busy
);

    go_ctrl_pkg::engine_state_t state;
    go_geom_pkg::point_t        move_pt;
    go_geom_pkg::point_t        scan;
    go_geom_pkg::point_t        nb;
    go_ctrl_pkg::dir_t          sweep;
    logic                       swept;
    logic                       self_grp;
    logic                       captured;
    logic                       idle;
    logic                       do_pass;
    logic                       do_place;
    logic                       suicide;

    assign idle     = state == go_ctrl_pkg::st_idle;
    assign do_pass  = idle && buttons.pass;
    assign do_place = idle && buttons.place && !buttons.pass && !cursor_occ;
    assign nb       = go_ctrl_pkg::neighbour(move_pt, sweep);
    assign suicide  = self_grp && !captured && !has_liberty;

    assign busy        = !idle;
    assign show_cursor = idle;
    assign probe_white = !turn_white;
    assign probe       = (state == go_ctrl_pkg::st_delete) ? scan : nb;

    // One board edit per cycle.
    always_comb begin
        edit = '0;
        case (state)
            go_ctrl_pkg::st_idle: begin
                edit.set   = do_place;
                edit.white = turn_white;
                edit.pt    = cursor;
            end
            go_ctrl_pkg::st_group_done: begin
                edit.clear = suicide;
                edit.white = turn_white;
                edit.pt    = move_pt;
            end
            go_ctrl_pkg::st_delete: begin
                edit.clear = member;
                edit.white = !turn_white;
                edit.pt    = scan;
            end
            default: edit = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= go_ctrl_pkg::st_idle;
            turn_white   <= 1'b0;
            search_start <= 1'b0;
            sweep        <= go_ctrl_pkg::dir_left;
            swept        <= 1'b0;
            self_grp     <= 1'b0;
            captured     <= 1'b0;
        end else begin
            search_start <= 1'b0;
            case (state)
                go_ctrl_pkg::st_idle: begin
                    if (do_pass) begin
                        turn_white <= ~turn_white;
                    end else if (do_place) begin
                        move_pt  <= cursor;
                        sweep    <= go_ctrl_pkg::dir_left;
                        swept    <= 1'b0;
                        self_grp <= 1'b0;
                        captured <= 1'b0;
                        state    <= go_ctrl_pkg::st_cap_dir;
                    end
                end
                go_ctrl_pkg::st_cap_dir: begin
                    if (probe_hit && !swept) begin
                        search_start <= 1'b1;
                        seed         <= nb;
                        search_white <= !turn_white;
                        state        <= go_ctrl_pkg::st_search;
                    end else if (sweep == go_ctrl_pkg::dir_down) begin
                        // All neighbours done, now the new stone's own group.
                        search_start <= 1'b1;
                        seed         <= move_pt;
                        search_white <= turn_white;
                        self_grp     <= 1'b1;
                        state        <= go_ctrl_pkg::st_search;
                    end else begin
                        sweep <= go_ctrl_pkg::dir_t'(sweep + 2'd1);
                        swept <= 1'b0;
                    end
                end
                go_ctrl_pkg::st_search: begin
                    if (search_done) begin
                        state <= go_ctrl_pkg::st_group_done;
                    end
                end
                go_ctrl_pkg::st_group_done: begin
                    if (self_grp) begin
                        if (!suicide) begin
                            turn_white <= ~turn_white;
                        end
                        state <= go_ctrl_pkg::st_idle;
                    end else if (!has_liberty) begin
                        captured <= 1'b1;
                        scan     <= go_geom_pkg::scan_origin;
                        state    <= go_ctrl_pkg::st_delete;
                    end else begin
                        swept <= 1'b1;
                        state <= go_ctrl_pkg::st_cap_dir;
                    end
                end
                go_ctrl_pkg::st_delete: begin
                    if (go_geom_pkg::raster_last(scan)) begin
                        swept <= 1'b1;
                        state <= go_ctrl_pkg::st_cap_dir;
                    end else begin
                        scan <= go_geom_pkg::raster_next(scan);
                    end
                end
                default: state <= go_ctrl_pkg::st_idle;
            endcase
        end
    end

endmodule

/* source/go_board.sv */
module go_board (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                up,
    input  logic                down,
    input  logic                left,
    input  logic                right,
    input  logic                place,
    input  logic                pass,
    output logic                black,
    output logic                white,
    output go_geom_pkg::plane_t rows,
    output logic                busy
);

    go_geom_pkg::point_t      cursor;
    go_geom_pkg::point_t      probe;
    go_geom_pkg::point_t      seed;
    go_geom_pkg::plane_t      black_plane;
    go_geom_pkg::plane_t      white_plane;
    go_ctrl_pkg::buttons_t    buttons;
    go_ctrl_pkg::board_edit_t edit;
    logic                     cursor_occ;
    logic                     probe_hit;
    logic                     probe_white;
    logic                     show_cursor;
    logic                     turn_white;
    logic                     search_start;
    logic                     search_white;
    logic                     search_done;
    logic                     has_liberty;
    logic                     member;

    cursor_ctrl u_cursor (
        .clk     (clk),
        .rst_n   (rst_n),
        .up      (up),
        .down    (down),
        .left    (left),
        .right   (right),
        .place   (place),
        .pass    (pass),
        .cursor  (cursor),
        .buttons (buttons)
    );

    board_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .edit        (edit),
        .cursor      (cursor),
        .show_cursor (show_cursor),
        .turn_white  (turn_white),
        .probe       (probe),
        .probe_white (probe_white),
        .cursor_occ  (cursor_occ),
        .probe_hit   (probe_hit),
        .black_plane (black_plane),
        .white_plane (white_plane),
        .black       (black),
        .white       (white),
        .rows        (rows)
    );

    group_search u_search (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (search_start),
        .seed         (seed),
        .search_white (search_white),
        .black_plane  (black_plane),
        .white_plane  (white_plane),
        .probe        (probe),
        .done         (search_done),
        .has_liberty  (has_liberty),
        .member       (member)
    );

    move_ctrl u_move (
        .clk          (clk),
        .rst_n        (rst_n),
        .buttons      (buttons),
        .cursor       (cursor),
        .cursor_occ   (cursor_occ),
        .probe_hit    (probe_hit),
        .search_done  (search_done),
        .has_liberty  (has_liberty),
        .member       (member),
        .edit         (edit),
        .probe        (probe),
        .probe_white  (probe_white),
        .search_start (search_start),
        .seed         (seed),
        .search_white (search_white),
        .turn_white   (turn_white),
        .show_cursor  (show_cursor),
        .busy         (busy)
    );

endmodule

/* tests/go_board_asserts.sv */
module go_board_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  black,
    input logic                  white,
    input logic                  busy,
    input go_ctrl_pkg::buttons_t buttons
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // The enables stay complementary and swap on every clock.
    phase_complement: assert property (
        @(posedge clk) disable iff (!rst_n)
            $past(rst_n) |-> (black != white) && (black != $past(black))
    ) else begin
        failures++;
        $error("black and white phase enables do not alternate as a complementary pair");
    end

    // Engine leaves reset idle.
    idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !busy
    ) else begin
        failures++;
        $error("busy is high in the first cycle after reset");
    end

    pass_stays_idle: assert property (
        @(posedge clk) disable iff (!rst_n) (!busy && buttons.pass) |=> !busy
    ) else begin
        failures++;
        $error("a pass in the idle state raised busy");
    end

endmodule

bind go_board go_board_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .black   (black),
    .white   (white),
    .busy    (busy),
    .buttons (buttons)
);

/* tests/go_board_tb.sv */
module go_board_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          num_moves       = 14;
    localparam int          watchdog_cycles = num_moves * 2000;
    localparam int          busy_limit      = 1500;
    localparam logic [31:0] rand_seed       = 32'h7425_7db5;

    typedef enum logic {
        act_place,
        act_pass
    } action_t;

    typedef struct packed {
        logic [3:0]          col;
        logic [3:0]          row;
        action_t             act;
        go_geom_pkg::plane_t exp_black;
        go_geom_pkg::plane_t exp_white;
    } move_t;

    logic                clk;
    logic                rst_n;
    logic                up;
    logic                down;
    logic                left;
    logic                right;
    logic                place;
    logic                pass;
    logic                black;
    logic                white;
    logic                busy;
    go_geom_pkg::plane_t rows;

    move_t moves [num_moves];
    string move_names [num_moves];
    int    fill_idx;
    int    errors;

    // Reference state: cursor, player to move and the board before the move.
    int                  cur_x;
    int                  cur_y;
    logic                white_to_move;
    go_geom_pkg::plane_t prev_black;
    go_geom_pkg::plane_t prev_white;

    go_board u_go_board (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (up),
        .down  (down),
        .left  (left),
        .right (right),
        .place (place),
        .pass  (pass),
        .black (black),
        .white (white),
        .rows  (rows),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Row r holds bits 9r to 9r+8, column c is bit c of the row.
    function automatic go_geom_pkg::plane_t stone_at(int col, int row);
        return go_geom_pkg::plane_t'(1) << (go_geom_pkg::board_size * row + col);
    endfunction

    task automatic add_move(input string name, input int col, input int row,
                            input action_t act, input go_geom_pkg::plane_t eb,
                            input go_geom_pkg::plane_t ew);
        moves[fill_idx].col       = 4'(col);
        moves[fill_idx].row       = 4'(row);
        moves[fill_idx].act       = act;
        moves[fill_idx].exp_black = eb;
        moves[fill_idx].exp_white = ew;
        move_names[fill_idx]      = name;
        fill_idx++;
    endtask

    task automatic load_table();
        go_geom_pkg::plane_t b;
        go_geom_pkg::plane_t w;
        b = '0;
        w = '0;
        b |= stone_at(4, 7);
        add_move("b_first", 4, 7, act_place, b, w);
        w |= stone_at(4, 8);
        add_move("w_edge", 4, 8, act_place, b, w);
        add_move("b_occupied", 4, 8, act_place, b, w);
        b |= stone_at(3, 8);
        add_move("b_left_of_pair", 3, 8, act_place, b, w);
        w |= stone_at(5, 8);
        add_move("w_pair", 5, 8, act_place, b, w);
        b |= stone_at(5, 7);
        add_move("b_above_pair", 5, 7, act_place, b, w);
        add_move("w_pass", 4, 4, act_pass, b, w);
        b |= stone_at(1, 0);
        add_move("b_after_pass", 1, 0, act_place, b, w);
        w |= stone_at(2, 0);
        add_move("w_top_edge", 2, 0, act_place, b, w);
        b |= stone_at(0, 1);
        add_move("b_corner_eye", 0, 1, act_place, b, w);
        add_move("w_suicide", 0, 0, act_place, b, w);
        w |= stone_at(1, 1);
        add_move("w_atari", 1, 1, act_place, b, w);
        // Last liberty of the white pair on the lower edge.
        b |= stone_at(6, 8);
        w &= ~(stone_at(4, 8) | stone_at(5, 8));
        add_move("b_capture_pair", 6, 8, act_place, b, w);
        // Same point as the refused move, now it takes a stone.
        w |= stone_at(0, 0);
        b &= ~stone_at(1, 0);
        add_move("w_capture_in_eye", 0, 0, act_place, b, w);
    endtask

    task automatic press_dir(input go_ctrl_pkg::dir_t d);
        int last_idx;
        last_idx = go_geom_pkg::board_size - 1;
        case (d)
            go_ctrl_pkg::dir_left:  left  = 1'b1;
            go_ctrl_pkg::dir_right: right = 1'b1;
            go_ctrl_pkg::dir_up:    up    = 1'b1;
            go_ctrl_pkg::dir_down:  down  = 1'b1;
        endcase
        @(posedge clk);
        #1;
        {left, right, up, down} = 4'b0000;
        @(posedge clk);
        #1;
        // The cursor stops at the board edge.
        case (d)
            go_ctrl_pkg::dir_left:  cur_x = (cur_x > 0) ? cur_x - 1 : cur_x;
            go_ctrl_pkg::dir_right: cur_x = (cur_x < last_idx) ? cur_x + 1 : cur_x;
            go_ctrl_pkg::dir_up:    cur_y = (cur_y > 0) ? cur_y - 1 : cur_y;
            go_ctrl_pkg::dir_down:  cur_y = (cur_y < last_idx) ? cur_y + 1 : cur_y;
        endcase
    endtask

    // Push into the upper left corner with extra presses, then count out.
    task automatic go_to(input int col, input int row);
        int extra;
        extra = 1 + int'($urandom % 3);
        repeat (cur_x + extra) begin
            press_dir(go_ctrl_pkg::dir_left);
        end
        extra = 1 + int'($urandom % 3);
        repeat (cur_y + extra) begin
            press_dir(go_ctrl_pkg::dir_up);
        end
        repeat (col) begin
            press_dir(go_ctrl_pkg::dir_right);
        end
        repeat (row) begin
            press_dir(go_ctrl_pkg::dir_down);
        end
    endtask

    task automatic check_display(input string name, input go_geom_pkg::plane_t exp_b,
                                 input go_geom_pkg::plane_t exp_w);
        go_geom_pkg::plane_t cur_mask;
        go_geom_pkg::plane_t want_b;
        go_geom_pkg::plane_t want_w;
        go_geom_pkg::plane_t got_b;
        go_geom_pkg::plane_t got_w;
        cur_mask = stone_at(cur_x, cur_y);
        want_b   = exp_b;
        want_w   = exp_w;
        // Cursor lights in the mover's phase over an empty point.
        if (((exp_b | exp_w) & cur_mask) == '0) begin
            if (white_to_move) begin
                want_w = want_w | cur_mask;
            end else begin
                want_b = want_b | cur_mask;
            end
        end
        got_b = '0;
        got_w = '0;
        repeat (2) begin
            @(negedge clk);
            if (black) begin
                got_b = rows;
            end else begin
                got_w = rows;
            end
        end
        assert (got_b == want_b) else begin
            errors++;
            $display("ERR %s black phase: expected %h actual %h", name, want_b, got_b);
        end
        assert (got_w == want_w) else begin
            errors++;
            $display("ERR %s white phase: expected %h actual %h", name, want_w, got_w);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic apply_move(input int idx);
        move_t m;
        int    waited;
        m = moves[idx];
        go_to(int'(m.col), int'(m.row));
        if (m.act == act_pass) begin
            pass = 1'b1;
        end else begin
            place = 1'b1;
        end
        @(posedge clk);
        #1;
        place = 1'b0;
        pass  = 1'b0;
        @(posedge clk);
        #1;
        // A taken placement has raised busy by now.
        waited = 0;
        while (busy && waited < busy_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (!busy) else begin
            errors++;
            $display("Engine still busy %0d cycles into move %s", busy_limit, move_names[idx]);
        end
        // A pass or any change on the board hands over the turn.
        if (m.act == act_pass || m.exp_black != prev_black || m.exp_white != prev_white) begin
            white_to_move = ~white_to_move;
        end
        prev_black = m.exp_black;
        prev_white = m.exp_white;
        check_display(move_names[idx], m.exp_black, m.exp_white);
    endtask

    initial begin
        int extra;
        rst_n = 1'b0;
        up    = 1'b0;
        down  = 1'b0;
        left  = 1'b0;
        right = 1'b0;
        place = 1'b0;
        pass  = 1'b0;
        void'($urandom(rand_seed));
        errors        = 0;
        fill_idx      = 0;
        cur_x         = 4;
        cur_y         = 4;
        white_to_move = 1'b0;
        prev_black    = '0;
        prev_white    = '0;
        load_table();
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        // Run past the lower right corner on an empty board.
        extra = 1 + int'($urandom % 4);
        repeat (4 + extra) begin
            press_dir(go_ctrl_pkg::dir_right);
        end
        extra = 1 + int'($urandom % 4);
        repeat (4 + extra) begin
            press_dir(go_ctrl_pkg::dir_down);
        end
        check_display("cursor_corner", '0, '0);

        for (int i = 0; i < num_moves; i++) begin
            apply_move(i);
        end

        $display("Run complete: %0d check errors, %0d assertion failures",
                 errors, u_go_board.u_asserts.failures);
        if (errors == 0 && u_go_board.u_asserts.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not end within %0d cycles", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* all.f */
source/go_geom_pkg.sv
source/go_ctrl_pkg.sv
source/cursor_ctrl.sv
source/board_store.sv
source/group_search.sv
source/move_ctrl.sv
source/go_board.sv
tests/go_board_asserts.sv
tests/go_board_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the go_board testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module go_board_tb -Mdir obj_dir -f all.f \
    || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/Vgo_board_tb +verilator+error+limit+1000)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASS" && exit 0 || exit 1
